//--- design/rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// ********************************************************************
// rob sizing
// ********************************************************************

// entries in each thread queue, must stay a power of two
`define ROB_SIZE 8

// index bits for one queue, log2 of ROB_SIZE
`define ROB_IDX_WIDTH 3

// architected register number, 32 arch regs
`define ARN_WIDTH 5

// physical register number, 64 physical regs
`define PRN_WIDTH 6

// completion ports: mult x2, add x2, mem x2
`define FU_COUNT 6

`endif

//--- design/rob_pkg.sv
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

	typedef logic [`ROB_IDX_WIDTH-1:0] rob_idx_t;	// slot inside one thread queue
	typedef logic [`ROB_IDX_WIDTH:0] rob_count_t;	// 0 .. ROB_SIZE, needs one extra bit
	typedef logic [`ARN_WIDTH-1:0] arn_t;
	typedef logic [`PRN_WIDTH-1:0] prn_t;

	// tag handed to the rs and returned by the fus
	typedef struct packed {
		logic thread1;		// 1 = thread 1 queue, 0 = thread 2 queue
		rob_idx_t idx;
	} rob_tag_t;

	// one dispatch slot from rename
	typedef struct packed {
		logic load;		// slot carries an instruction this cycle
		logic thread1;
		logic is_branch;
		arn_t arn;		// dest arch reg
		prn_t prn;		// dest phys reg
	} dispatch_slot_t;

	// completion strobe from one fu
	typedef struct packed {
		logic done;
		rob_tag_t tag;
	} fu_done_t;

	// oldest two entries of one queue
	typedef struct packed {
		logic oldest_ready;	// valid and executed
		logic oldest_is_branch;
		arn_t oldest_arn;
		prn_t oldest_prn;
		logic second_ready;
		logic second_is_branch;
		arn_t second_arn;
		prn_t second_prn;
	} head_pair_t;

	typedef struct packed {
		logic valid;
		logic is_branch;
		arn_t arn;
		prn_t prn;
		rob_tag_t tag;
	} commit_slot_t;

	// thread-1 count first, then thread-2 count
	typedef enum logic [2:0] {
		ZERO_ZERO,
		ONE_ZERO,
		TWO_ZERO,
		ONE_ONE,
		ZERO_ONE,
		ZERO_TWO
	} commit_mode_t;

endpackage

`default_nettype wire

//--- design/rob_dispatch_steer.sv
`default_nettype none

`include "rob_defines.svh"

module rob_dispatch_steer (
	input rob_pkg::dispatch_slot_t inst1,
	input rob_pkg::dispatch_slot_t inst2,
	input rob_pkg::rob_idx_t t1_tail,
	input rob_pkg::rob_idx_t t2_tail,
	input rob_pkg::rob_count_t t1_count,
	input rob_pkg::rob_count_t t2_count,
	output rob_pkg::rob_tag_t inst1_tag,
	output rob_pkg::rob_tag_t inst2_tag,
	output logic dispatch_stall,
	output rob_pkg::rob_count_t t1_alloc,
	output rob_pkg::rob_count_t t2_alloc,
	output logic t1_wr1,
	output logic t1_wr2,
	output logic t2_wr1,
	output logic t2_wr2,
	output rob_pkg::rob_idx_t t1_wr2_idx,
	output rob_pkg::rob_idx_t t2_wr2_idx
);

	logic ld1_t1, ld1_t2, ld2_t1, ld2_t2;		// slot x loaded for thread y
	rob_pkg::rob_count_t t1_need, t2_need;

	// ********************************************************************
	// classify slots by thread
	// ********************************************************************
	assign ld1_t1 = inst1.load & inst1.thread1;
	assign ld1_t2 = inst1.load & ~inst1.thread1;
	assign ld2_t1 = inst2.load & inst2.thread1;
	assign ld2_t2 = inst2.load & ~inst2.thread1;

	assign t1_need = rob_pkg::rob_count_t'(ld1_t1) + rob_pkg::rob_count_t'(ld2_t1);
	assign t2_need = rob_pkg::rob_count_t'(ld1_t2) + rob_pkg::rob_count_t'(ld2_t2);

	// full check, same-cycle commits are ignored on purpose (conservative)
	assign dispatch_stall = ((t1_count + t1_need) > `ROB_SIZE) ||
		((t2_count + t2_need) > `ROB_SIZE);

	// ********************************************************************
	// tags
	// ********************************************************************
	// inst2 sits one past the tail only if inst1 went to the same queue
	assign t1_wr2_idx = t1_tail + rob_pkg::rob_idx_t'(ld1_t1);
	assign t2_wr2_idx = t2_tail + rob_pkg::rob_idx_t'(ld1_t2);

	assign inst1_tag.thread1 = inst1.thread1;
	assign inst1_tag.idx = inst1.thread1 ? t1_tail : t2_tail;	// inst1 always at tail
	assign inst2_tag.thread1 = inst2.thread1;
	assign inst2_tag.idx = inst2.thread1 ? t1_wr2_idx : t2_wr2_idx;

	// allocation, all killed by stall
	assign t1_wr1 = ld1_t1 & ~dispatch_stall;
	assign t1_wr2 = ld2_t1 & ~dispatch_stall;
	assign t2_wr1 = ld1_t2 & ~dispatch_stall;
	assign t2_wr2 = ld2_t2 & ~dispatch_stall;
	assign t1_alloc = dispatch_stall ? '0 : t1_need;
	assign t2_alloc = dispatch_stall ? '0 : t2_need;

endmodule

`default_nettype wire

//--- design/rob_pointers.sv
`default_nettype none

`include "rob_defines.svh"

module rob_pointers (
	input wire logic clock,
	input wire logic reset,
	input rob_pkg::rob_count_t t1_alloc,
	input rob_pkg::rob_count_t t2_alloc,
	input rob_pkg::rob_count_t t1_retire,
	input rob_pkg::rob_count_t t2_retire,
	output rob_pkg::rob_idx_t t1_head,
	output rob_pkg::rob_idx_t t2_head,
	output rob_pkg::rob_idx_t t1_tail,
	output rob_pkg::rob_idx_t t2_tail,
	output rob_pkg::rob_count_t t1_count,
	output rob_pkg::rob_count_t t2_count
);

	// ********************************************************************
	// head, tail, count per thread
	// ********************************************************************
	// indices wrap for free, ROB_SIZE is a power of two
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			t1_head <= '0;
			t1_tail <= '0;
			t1_count <= '0;
			t2_head <= '0;
			t2_tail <= '0;
			t2_count <= '0;
		end
		else
		begin
			t1_tail <= t1_tail + rob_pkg::rob_idx_t'(t1_alloc);	// 0..2 new entries
			t1_head <= t1_head + rob_pkg::rob_idx_t'(t1_retire);	// 0..2 retired
			t1_count <= t1_count + t1_alloc - t1_retire;
			t2_tail <= t2_tail + rob_pkg::rob_idx_t'(t2_alloc);
			t2_head <= t2_head + rob_pkg::rob_idx_t'(t2_retire);
			t2_count <= t2_count + t2_alloc - t2_retire;
		end
	end

	// stall logic in the steer must keep the queues from overflowing
	a_t1_count_max : assert property (@(posedge clock) disable iff (reset)
		t1_count <= `ROB_SIZE);
	a_t2_count_max : assert property (@(posedge clock) disable iff (reset)
		t2_count <= `ROB_SIZE);

	// commit select only retires live entries
	a_t1_retire_live : assert property (@(posedge clock) disable iff (reset)
		t1_retire <= t1_count);
	a_t2_retire_live : assert property (@(posedge clock) disable iff (reset)
		t2_retire <= t2_count);

endmodule

`default_nettype wire

//--- design/rob_entry_array.sv
`default_nettype none

`include "rob_defines.svh"

module rob_entry_array #(
	parameter bit THREAD_ID = 1'b1		// 1 = thread 1 queue, 0 = thread 2
) (
	input wire logic clock,
	input wire logic reset,
	input rob_pkg::dispatch_slot_t inst1,
	input rob_pkg::dispatch_slot_t inst2,
	input wire logic wr1,
	input wire logic wr2,
	input rob_pkg::rob_idx_t wr1_idx,		// tail
	input rob_pkg::rob_idx_t wr2_idx,
	input rob_pkg::fu_done_t [`FU_COUNT-1:0] fu_done,
	input rob_pkg::rob_idx_t head,
	input rob_pkg::rob_count_t retire,
	output rob_pkg::head_pair_t head_pair
);

	logic [`ROB_SIZE-1:0] valid;
	logic [`ROB_SIZE-1:0] executed;
	logic [`ROB_SIZE-1:0] is_branch;
	rob_pkg::arn_t arn [`ROB_SIZE];
	rob_pkg::prn_t prn [`ROB_SIZE];

	logic [`FU_COUNT-1:0][`ROB_SIZE-1:0] done_onehot;	// one row per fu
	logic [`ROB_SIZE-1:0] done_vec;
	rob_pkg::rob_idx_t head_next;

	// ********************************************************************
	// completion decode
	// ********************************************************************
	always_comb
	begin
		done_vec = '0;
		for (int f = 0; f < `FU_COUNT; f++)
		begin
			done_onehot[f] = '0;
			if (fu_done[f].done && (fu_done[f].tag.thread1 == THREAD_ID))	// ours only
				done_onehot[f][fu_done[f].tag.idx] = 1'b1;
			done_vec = done_vec | done_onehot[f];
		end
	end

	// ********************************************************************
	// entry state
	// ********************************************************************
	assign head_next = head + 1'b1;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			executed <= '0;
		end
		else
		begin
			executed <= executed | done_vec;
			if (retire != '0)
				valid[head] <= 1'b0;
			if (retire == rob_pkg::rob_count_t'(2))
				valid[head_next] <= 1'b0;
			// new entries last; they never land on a live slot
			if (wr1)
			begin
				valid[wr1_idx] <= 1'b1;
				executed[wr1_idx] <= 1'b0;
			end
			if (wr2)
			begin
				valid[wr2_idx] <= 1'b1;
				executed[wr2_idx] <= 1'b0;
			end
		end
	end

	// payload
	always_ff @(posedge clock)
	begin
		if (wr1)
		begin
			is_branch[wr1_idx] <= inst1.is_branch;
			arn[wr1_idx] <= inst1.arn;
			prn[wr1_idx] <= inst1.prn;
		end
		if (wr2)
		begin
			is_branch[wr2_idx] <= inst2.is_branch;
			arn[wr2_idx] <= inst2.arn;
			prn[wr2_idx] <= inst2.prn;
		end
	end

	// head readout
	assign head_pair.oldest_ready = valid[head] & executed[head];
	assign head_pair.oldest_is_branch = is_branch[head];
	assign head_pair.oldest_arn = arn[head];
	assign head_pair.oldest_prn = prn[head];
	assign head_pair.second_ready = valid[head_next] & executed[head_next];
	assign head_pair.second_is_branch = is_branch[head_next];
	assign head_pair.second_arn = arn[head_next];
	assign head_pair.second_prn = prn[head_next];

	// an fu may only complete something that was dispatched and not yet retired
	for (genvar g = 0; g < `FU_COUNT; g++)
	begin : g_done_chk
		a_done_live : assert property (@(posedge clock) disable iff (reset)
			(fu_done[g].done && (fu_done[g].tag.thread1 == THREAD_ID))
			|-> valid[fu_done[g].tag.idx]);
	end

endmodule

`default_nettype wire

//--- design/rob_commit_select.sv
`default_nettype none

`include "rob_defines.svh"

module rob_commit_select (
	input rob_pkg::head_pair_t t1_pair,
	input rob_pkg::head_pair_t t2_pair,
	input rob_pkg::rob_idx_t t1_head,
	input rob_pkg::rob_idx_t t2_head,
	output rob_pkg::commit_slot_t commit1,
	output rob_pkg::commit_slot_t commit2,
	output rob_pkg::rob_count_t t1_retire,
	output rob_pkg::rob_count_t t2_retire
);

	// build one valid commit slot
	function automatic rob_pkg::commit_slot_t make_slot(input logic thread1,
			input rob_pkg::rob_idx_t idx, input logic is_branch,
			input rob_pkg::arn_t arn, input rob_pkg::prn_t prn);
		rob_pkg::commit_slot_t s;
		s.valid = 1'b1;
		s.is_branch = is_branch;
		s.arn = arn;
		s.prn = prn;
		s.tag.thread1 = thread1;
		s.tag.idx = idx;
		return s;
	endfunction

	rob_pkg::commit_mode_t mode;
	logic [1:0] t1_ready_n, t2_ready_n;	// 0, 1 or 2 in order
	rob_pkg::rob_idx_t t1_second, t2_second;

	// second only counts behind a ready oldest
	assign t1_ready_n = !t1_pair.oldest_ready ? 2'd0 : (t1_pair.second_ready ? 2'd2 : 2'd1);
	assign t2_ready_n = !t2_pair.oldest_ready ? 2'd0 : (t2_pair.second_ready ? 2'd2 : 2'd1);
	assign t1_second = t1_head + 1'b1;
	assign t2_second = t2_head + 1'b1;

	// ********************************************************************
	// mode pick with thread 1 at fixed priority
	// ********************************************************************
	always_comb
	begin
		if (t1_ready_n == 2'd2)
			mode = rob_pkg::TWO_ZERO;
		else if (t1_ready_n == 2'd1)
			mode = (t2_ready_n != 2'd0) ? rob_pkg::ONE_ONE : rob_pkg::ONE_ZERO;
		else if (t2_ready_n == 2'd2)
			mode = rob_pkg::ZERO_TWO;
		else if (t2_ready_n == 2'd1)
			mode = rob_pkg::ZERO_ONE;
		else
			mode = rob_pkg::ZERO_ZERO;
	end

	always_comb
	begin
		commit1 = '0;		// idle ports read all zero
		commit2 = '0;
		t1_retire = '0;
		t2_retire = '0;
		case (mode)
			rob_pkg::TWO_ZERO:
			begin
				commit1 = make_slot(1'b1, t1_head, t1_pair.oldest_is_branch,
					t1_pair.oldest_arn, t1_pair.oldest_prn);
				commit2 = make_slot(1'b1, t1_second, t1_pair.second_is_branch,
					t1_pair.second_arn, t1_pair.second_prn);
				t1_retire = rob_pkg::rob_count_t'(2);
			end
			rob_pkg::ONE_ONE, rob_pkg::ONE_ZERO:
			begin
				commit1 = make_slot(1'b1, t1_head, t1_pair.oldest_is_branch,
					t1_pair.oldest_arn, t1_pair.oldest_prn);
				t1_retire = rob_pkg::rob_count_t'(1);
				if (mode == rob_pkg::ONE_ONE)
				begin
					commit2 = make_slot(1'b0, t2_head, t2_pair.oldest_is_branch,
						t2_pair.oldest_arn, t2_pair.oldest_prn);
					t2_retire = rob_pkg::rob_count_t'(1);
				end
			end
			rob_pkg::ZERO_TWO, rob_pkg::ZERO_ONE:
			begin
				commit1 = make_slot(1'b0, t2_head, t2_pair.oldest_is_branch,
					t2_pair.oldest_arn, t2_pair.oldest_prn);
				t2_retire = rob_pkg::rob_count_t'(1);
				if (mode == rob_pkg::ZERO_TWO)
				begin
					commit2 = make_slot(1'b0, t2_second, t2_pair.second_is_branch,
						t2_pair.second_arn, t2_pair.second_prn);
					t2_retire = rob_pkg::rob_count_t'(2);
				end
			end
			default:
			begin
				t1_retire = '0;	// ZERO_ZERO retires nothing
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/rob_top.sv
`default_nettype none

`include "rob_defines.svh"

module rob_top (
	input wire logic clock,
	input wire logic reset,
	input rob_pkg::dispatch_slot_t inst1,
	input rob_pkg::dispatch_slot_t inst2,
	input rob_pkg::fu_done_t [`FU_COUNT-1:0] fu_done,	// mult1, mult2, add1, add2, mem1, mem2
	output rob_pkg::rob_tag_t inst1_tag,
	output rob_pkg::rob_tag_t inst2_tag,
	output logic dispatch_stall,
	output rob_pkg::commit_slot_t commit1,
	output rob_pkg::commit_slot_t commit2
);

	// pointer state
	rob_pkg::rob_idx_t t1_head, t2_head;
	rob_pkg::rob_idx_t t1_tail, t2_tail;
	rob_pkg::rob_count_t t1_count, t2_count;

	// dispatch side
	rob_pkg::rob_count_t t1_alloc, t2_alloc;
	logic t1_wr1, t1_wr2, t2_wr1, t2_wr2;
	rob_pkg::rob_idx_t t1_wr2_idx, t2_wr2_idx;

	// commit side
	rob_pkg::head_pair_t t1_pair, t2_pair;
	rob_pkg::rob_count_t t1_retire, t2_retire;

	rob_dispatch_steer u_steer (
		.inst1, .inst2,
		.t1_tail, .t2_tail, .t1_count, .t2_count,
		.inst1_tag, .inst2_tag, .dispatch_stall,
		.t1_alloc, .t2_alloc,
		.t1_wr1, .t1_wr2, .t2_wr1, .t2_wr2,
		.t1_wr2_idx, .t2_wr2_idx
	);

	rob_pointers u_pointers (
		.clock, .reset,
		.t1_alloc, .t2_alloc, .t1_retire, .t2_retire,
		.t1_head, .t2_head, .t1_tail, .t2_tail,
		.t1_count, .t2_count
	);

	// thread 1 queue
	rob_entry_array #(.THREAD_ID(1'b1)) u_t1_array (
		.clock, .reset, .inst1, .inst2,
		.wr1(t1_wr1), .wr2(t1_wr2), .wr1_idx(t1_tail), .wr2_idx(t1_wr2_idx),
		.fu_done, .head(t1_head), .retire(t1_retire), .head_pair(t1_pair)
	);

	// thread 2 queue
	rob_entry_array #(.THREAD_ID(1'b0)) u_t2_array (
		.clock, .reset, .inst1, .inst2,
		.wr1(t2_wr1), .wr2(t2_wr2), .wr1_idx(t2_tail), .wr2_idx(t2_wr2_idx),
		.fu_done, .head(t2_head), .retire(t2_retire), .head_pair(t2_pair)
	);

	rob_commit_select u_commit (
		.t1_pair, .t2_pair, .t1_head, .t2_head,
		.commit1, .commit2, .t1_retire, .t2_retire
	);

endmodule

`default_nettype wire

//--- tests/tb_rob.sv
`default_nettype none

`include "rob_defines.svh"

module tb_rob;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int rob_size = `ROB_SIZE;
	localparam int clock_period = 40;
	localparam int watchdog_cycles = 600;	// tests need about 200 cycles

	logic clock;
	logic reset;
	rob_pkg::dispatch_slot_t inst1, inst2;
	rob_pkg::fu_done_t [`FU_COUNT-1:0] fu_done;	// mult1, mult2, add1, add2, mem1, mem2
	rob_pkg::rob_tag_t inst1_tag, inst2_tag;
	logic dispatch_stall;
	rob_pkg::commit_slot_t commit1, commit2;

	// reference queues with index 0 for thread 1 and index 1 for thread 2
	int m_head [2];
	int m_tail [2];
	int m_count [2];
	bit m_valid [2][rob_size];
	bit m_exec [2][rob_size];
	rob_pkg::dispatch_slot_t m_slot [2][rob_size];	// payload as dispatched

	int errors;
	int tests_run;
	int base_errors;	// error count when the current test began
	int seq;		// payload generator
	int dispatched;
	int observed;		// valid commits seen on the DUT ports
	integer seed = 50908;

	rob_top rob_top_i (
		.clock, .reset, .inst1, .inst2, .fu_done,
		.inst1_tag, .inst2_tag, .dispatch_stall, .commit1, .commit2
	);

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// ********************************************************************
	// helpers
	// ********************************************************************
	function automatic int queue_of(input logic thread1);
		return thread1 ? 0 : 1;
	endfunction

	// fresh loaded slot with a payload nobody else carries
	function automatic rob_pkg::dispatch_slot_t new_slot(input logic thread1);
		rob_pkg::dispatch_slot_t s;
		seq++;
		s.load = 1'b1;
		s.thread1 = thread1;
		s.is_branch = seq[1];
		s.arn = rob_pkg::arn_t'(seq * 7);
		s.prn = rob_pkg::prn_t'(seq * 5 + 3);
		return s;
	endfunction

	// 0, 1 or 2 in-order ready entries at the head
	function automatic int ready_count(input int q);
		int h;
		int h2;
		h = m_head[q];
		h2 = (h + 1) % rob_size;
		if (!(m_valid[q][h] && m_exec[q][h]))
			return 0;
		if (m_valid[q][h2] && m_exec[q][h2])
			return 2;
		return 1;
	endfunction

	function automatic rob_pkg::commit_slot_t expect_slot(input int q, input int off);
		rob_pkg::commit_slot_t c;
		int i;
		i = (m_head[q] + off) % rob_size;
		c.valid = 1'b1;
		c.is_branch = m_slot[q][i].is_branch;
		c.arn = m_slot[q][i].arn;
		c.prn = m_slot[q][i].prn;
		c.tag.thread1 = (q == 0);
		c.tag.idx = rob_pkg::rob_idx_t'(i);
		return c;
	endfunction

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
			errors++;
		end
	endtask

	task automatic write_entry(input int q, input rob_pkg::dispatch_slot_t s);
		m_slot[q][m_tail[q]] = s;
		m_valid[q][m_tail[q]] = 1'b1;
		m_exec[q][m_tail[q]] = 1'b0;
		m_tail[q] = (m_tail[q] + 1) % rob_size;
		m_count[q]++;
		dispatched++;
	endtask

	// ********************************************************************
	// one cycle of output checks and model update up to the next edge
	// ********************************************************************
	task automatic step();
		int q1;
		int q2;
		int need [2];
		int n [2];
		int r [2];
		bit stall;
		rob_pkg::rob_tag_t tag;
		rob_pkg::commit_slot_t c1;
		rob_pkg::commit_slot_t c2;
		#10;	// comb outputs settled well before the edge
		q1 = queue_of(inst1.thread1);
		q2 = queue_of(inst2.thread1);
		need[0] = 0;
		need[1] = 0;
		if (inst1.load)
			need[q1]++;
		if (inst2.load)
			need[q2]++;
		stall = (m_count[0] + need[0] > rob_size) || (m_count[1] + need[1] > rob_size);
		check_val("dispatch_stall", stall, dispatch_stall);
		if (!stall && inst1.load)
		begin
			tag.thread1 = inst1.thread1;
			tag.idx = rob_pkg::rob_idx_t'(m_tail[q1]);	// inst1 always at the tail
			check_val("inst1_tag", tag, inst1_tag);
		end
		if (!stall && inst2.load)
		begin
			tag.thread1 = inst2.thread1;
			tag.idx = rob_pkg::rob_idx_t'((m_tail[q2] + ((inst1.load && q1 == q2) ? 1 : 0))
				% rob_size);
			check_val("inst2_tag", tag, inst2_tag);
		end

		// commit mode with thread 1 first
		c1 = '0;
		c2 = '0;
		r[0] = 0;
		r[1] = 0;
		n[0] = ready_count(0);
		n[1] = ready_count(1);
		if (n[0] == 2)
		begin
			c1 = expect_slot(0, 0);
			c2 = expect_slot(0, 1);
			r[0] = 2;
		end
		else if (n[0] == 1)
		begin
			c1 = expect_slot(0, 0);
			r[0] = 1;
			if (n[1] > 0)
			begin
				c2 = expect_slot(1, 0);	// one from each thread
				r[1] = 1;
			end
		end
		else if (n[1] > 0)
		begin
			c1 = expect_slot(1, 0);
			r[1] = 1;
			if (n[1] == 2)
			begin
				c2 = expect_slot(1, 1);
				r[1] = 2;
			end
		end
		check_val("commit1", c1, commit1);
		check_val("commit2", c2, commit2);
		observed += int'(commit1.valid) + int'(commit2.valid);

		// state at the coming edge
		for (int f = 0; f < `FU_COUNT; f++)
			if (fu_done[f].done)
				m_exec[queue_of(fu_done[f].tag.thread1)][fu_done[f].tag.idx] = 1'b1;
		for (int q = 0; q < 2; q++)
		begin
			for (int k = 0; k < r[q]; k++)
				m_valid[q][(m_head[q] + k) % rob_size] = 1'b0;
			m_head[q] = (m_head[q] + r[q]) % rob_size;
			m_count[q] -= r[q];
		end
		if (!stall && inst1.load)
			write_entry(q1, inst1);
		if (!stall && inst2.load)
			write_entry(q2, inst2);
		@(posedge clock);
		#2;
		inst1 = '0;
		inst2 = '0;
		fu_done = '0;
	endtask

	task automatic dispatch(input rob_pkg::dispatch_slot_t s1, input rob_pkg::dispatch_slot_t s2);
		inst1 = s1;
		inst2 = s2;
		step();
	endtask

	// strobe one fu port for the entry off places behind the head
	task automatic complete(input int port, input int q, input int off);
		fu_done[port].done = 1'b1;
		fu_done[port].tag.thread1 = (q == 0);
		fu_done[port].tag.idx = rob_pkg::rob_idx_t'((m_head[q] + off) % rob_size);
	endtask

	// commit everything left until model and DUT ports both go quiet
	task automatic drain();
		int n;
		n = 0;
		while ((m_count[0] + m_count[1] > 0 || commit1.valid || commit2.valid)
			&& n < 3 * rob_size)
		begin
			step();
			n++;
		end
		if (commit1.valid || commit2.valid)
		begin
			$display("commit ports still active after %0d drain cycles", n);
			errors++;
		end
		step();		// idle cycle with quiet ports
	endtask

	task automatic complete_all();
		int f;
		int i;
		do
		begin
			f = 0;
			for (int q = 0; q < 2; q++)
			begin
				for (int k = 0; k < m_count[q]; k++)
				begin
					i = (m_head[q] + k) % rob_size;
					if (!m_exec[q][i] && f < `FU_COUNT)
					begin
						complete(f, q, k);
						f++;
					end
				end
			end
			if (f > 0)
				step();
		end while (f > 0);
		drain();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %s finished, %0d errors", name, errors - base_errors);
		base_errors = errors;
	endtask

	// ********************************************************************
	// directed tests
	// ********************************************************************
	task automatic test_reset();
		#10;
		check_val("commit1.valid", 1'b0, commit1.valid);
		check_val("commit2.valid", 1'b0, commit2.valid);
		check_val("dispatch_stall", 1'b0, dispatch_stall);
		step();
		end_test("reset");
	endtask

	task automatic test_dispatch_tags();
		dispatch(new_slot(1'b1), new_slot(1'b1));	// both thread 1
		dispatch(new_slot(1'b1), new_slot(1'b0));	// split
		dispatch(new_slot(1'b0), new_slot(1'b0));	// both thread 2
		dispatch('0, new_slot(1'b1));			// lone inst2
		complete_all();
		// thread 1 tail sits at 4 so three pairs run it past the end
		repeat (3) dispatch(new_slot(1'b1), new_slot(1'b1));
		complete_all();
		end_test("dispatch_tags");
	endtask

	task automatic test_in_order();
		dispatch(new_slot(1'b1), new_slot(1'b1));
		dispatch(new_slot(1'b1), new_slot(1'b1));
		dispatch(new_slot(1'b0), new_slot(1'b0));
		complete(4, 0, 3);	// mem1 finishes the youngest first
		complete(1, 1, 1);
		step();
		complete(0, 0, 1);
		complete(2, 0, 2);
		step();
		step();			// oldest still busy so nothing commits
		complete(5, 0, 0);
		complete(3, 1, 0);
		step();
		drain();
		end_test("in_order");
	endtask

	task automatic test_commit_modes();
		// thread 1 two ready against thread 2 one ready
		dispatch(new_slot(1'b1), new_slot(1'b1));
		dispatch(new_slot(1'b0), new_slot(1'b0));
		complete(0, 0, 0);
		complete(1, 0, 1);
		complete(2, 1, 0);
		step();
		step();		// TWO_ZERO
		step();		// ZERO_ONE
		complete_all();
		// thread 1 one ready against thread 2 two ready
		dispatch(new_slot(1'b1), new_slot(1'b1));
		dispatch(new_slot(1'b0), new_slot(1'b0));
		complete(0, 0, 0);
		complete(3, 1, 0);
		complete(4, 1, 1);
		step();
		step();		// ONE_ONE
		step();		// ZERO_ONE while thread 1 second is busy
		complete_all();
		// thread 2 alone with both ready
		dispatch(new_slot(1'b0), new_slot(1'b0));
		complete(5, 1, 0);
		complete(2, 1, 1);
		step();
		drain();
		end_test("commit_modes");
	endtask

	task automatic test_full_stall();
		repeat (rob_size / 2) dispatch(new_slot(1'b1), new_slot(1'b1));
		complete(0, 0, 0);
		dispatch(new_slot(1'b1), '0);			// one too many so it stalls
		dispatch(new_slot(1'b1), new_slot(1'b0));	// commit not counted yet
		dispatch(new_slot(1'b1), '0);			// one slot free again
		complete_all();
		end_test("full_stall");
	endtask

	task automatic test_random();
		int r;
		int q;
		int i;
		bit picked [2][rob_size];
		dispatched = 0;
		observed = 0;
		repeat (60)
		begin
			r = $random(seed);
			if (r[0])
				inst1 = new_slot(r[1]);
			if (r[2])
				inst2 = new_slot(r[3]);
			picked = '{default: 1'b0};
			for (int f = 0; f < `FU_COUNT; f++)
			begin
				r = $random(seed);
				q = r[1] ? 1 : 0;
				if (r[0] && m_count[q] > 0)
				begin
					i = (m_head[q] + (int'(r[7:4]) % m_count[q])) % rob_size;
					if (!m_exec[q][i] && !picked[q][i])	// live and still busy
					begin
						picked[q][i] = 1'b1;
						complete(f, q, (i - m_head[q] + rob_size) % rob_size);
					end
				end
			end
			step();
		end
		complete_all();
		if (observed != dispatched)
		begin
			$display("%0d entries dispatched but %0d commits seen", dispatched, observed);
			errors++;
		end
		end_test("random_completion");
	endtask

	// ********************************************************************
	// main sequence
	// ********************************************************************
	initial
	begin
		inst1 = '0;
		inst2 = '0;
		fu_done = '0;
		reset = 1'b1;
		errors = 0;
		tests_run = 0;
		base_errors = 0;
		seq = 0;
		dispatched = 0;
		observed = 0;
		m_head = '{default: 0};
		m_tail = '{default: 0};
		m_count = '{default: 0};
		m_valid = '{default: 1'b0};
		m_exec = '{default: 1'b0};
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;

		test_reset();
		test_dispatch_tags();
		test_in_order();
		test_commit_modes();
		test_full_stall();
		test_random();

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// hard stop if something never drains
	initial
	begin
		#(watchdog_cycles * clock_period);
		$display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rob.f
+incdir+design
design/rob_pkg.sv
design/rob_dispatch_steer.sv
design/rob_pointers.sv
design/rob_entry_array.sv
design/rob_commit_select.sv
design/rob_top.sv
tests/tb_rob.sv
